// ==== vlog.f ====
ddr_test_pkg.sv
lfsr8.sv
test_data_gen.sv
test_addr_gen.sv
byte_enable_gen.sv
read_checker.sv
test_sequencer.sv
ddr_test_driver.sv
ddr_test_driver_sva.sv
ddr_test_driver_tb.sv

// ==== ddr_test_driver_tb.sv ====
/* testbench for the DDR traffic driver
   local port memory model with random ready and read latency and directed checks */
`timescale 1ns/1ns

module ddr_test_driver_tb
  import ddr_test_pkg::*;
();

  localparam int COLS   = MAX_COL / COL_STEP + 1;
  localparam int ROWS   = MAX_ROW + 1;
  localparam int BANKS  = MAX_BANK + 1;
  localparam int WINDOW = COLS * ROWS * BANKS * (MAX_CS + 1);
  // three write passes and two read passes per run
  localparam int PASSES = 5;
  // two runs at about half ready with a wide margin
  localparam int TIMEOUT_CYCLES = 10 * PASSES * WINDOW;

  logic              clk = 1'b0;
  logic              reset_n;
  logic              local_ready;
  logic [DATA_W-1:0] local_rdata;
  logic              local_rdata_valid;
  local_addr_t       local_addr;
  logic              local_write_req;
  logic              local_read_req;
  logic [DATA_W-1:0] local_wdata;
  logic [LANES-1:0]  local_be;
  logic [LANES-1:0]  pnf_per_byte;
  logic              pnf_persist;
  test_status_t      test_status;

  // memory model, read return queue and run bookkeeping
  logic [DATA_W-1:0] mem [local_addr_t];
  logic [DATA_W-1:0] dm_data [local_addr_t];
  logic [LANES-1:0]  dm_be [local_addr_t];
  logic [DATA_W-1:0] rq_data [$];
  int                rq_due [$];
  int                last_due;
  int                seed = 32'h405e07db;
  int                cycle = 0;
  int                accepts;
  int                reads;
  int                beats;
  int                dm_writes;
  int                corrupt_cycle;
  logic              inject_pending;
  logic              clean_run;
  logic              persist_seen;
  test_status_t      prev_status;
  int                mismatches = 0;
  int                failures = 0;

  always #20 clk = ~clk;

  ddr_test_driver dut (.*);

  task automatic compare_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
    assert (got === exp)
    else
    begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic confirm(input logic ok, input string what);
    assert (ok)
    else
    begin
      failures++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  // column first then row, bank and chip select
  function automatic local_addr_t window_addr(input int idx);
    local_addr_t a;
    a      = '0;
    a.col  = COL_W'((idx % COLS) * COL_STEP);
    a.row  = ROW_W'((idx / COLS) % ROWS);
    a.bank = BANK_W'((idx / (COLS * ROWS)) % BANKS);
    a.cs   = CS_W'(idx / (COLS * ROWS * BANKS));
    return a;
  endfunction

  // ------------------------------
  // memory model and monitors
  // ------------------------------
  always @(posedge clk)
  begin : memory_model
    local_addr_t       a;
    logic [DATA_W-1:0] word;
    logic [LANES-1:0]  exp_be;
    int                rnd;
    int                due;
    cycle <= cycle + 1;
    if (!reset_n)
    begin
      mem.delete();
      dm_data.delete();
      dm_be.delete();
      rq_data.delete();
      rq_due.delete();
      last_due = 0;
      local_ready       <= 1'b0;
      local_rdata_valid <= 1'b0;
      local_rdata       <= '0;
      accepts        <= 0;
      reads          <= 0;
      beats          <= 0;
      dm_writes      <= 0;
      corrupt_cycle  <= -1;
      inject_pending <= 1'b0;
      persist_seen   <= 1'b0;
      prev_status    <= '0;
    end
    else
    begin
      rnd = $random(seed);
      local_ready <= rnd[0];
      a = local_addr;
      if ((local_write_req || local_read_req) && local_ready)
      begin
        compare_value("local_addr", a, window_addr(accepts % WINDOW));
        accepts <= accepts + 1;
        if (local_write_req)
        begin
          word = mem.exists(a) ? mem[a] : '0;
          for (int l = 0; l < LANES; l++)
            if (local_be[l])
              word[l*LANE_W +: LANE_W] = local_wdata[l*LANE_W +: LANE_W];
          mem[a] = word;
          if (test_status.dm_mode && dm_writes >= WINDOW)
          begin
            // one lane per write starting at lane 0
            exp_be = LANES'(1) << ((dm_writes - WINDOW) % LANES);
            confirm($countones(local_be) == 1, "data-mask write without exactly one enable");
            compare_value("local_be", local_be, exp_be);
            dm_be[a]   = local_be;
            dm_data[a] = local_wdata;
          end
          else if (test_status.dm_mode)
          begin
            compare_value("local_wdata", local_wdata, '0);
            compare_value("local_be", local_be, {LANES{1'b1}});
          end
          if (test_status.dm_mode)
            dm_writes <= dm_writes + 1;
        end
        else
        begin
          rnd = $random(seed);
          due = cycle + 2 + (rnd[30:0] % 5);
          // keep returns in order
          if (due <= last_due)
            due = last_due + 1;
          last_due = due;
          rq_data.push_back(mem.exists(a) ? mem[a] : '0);
          rq_due.push_back(due);
          reads <= reads + 1;
        end
      end
      if (rq_due.size() > 0 && rq_due[0] <= cycle)
      begin
        word = rq_data.pop_front();
        void'(rq_due.pop_front());
        if (inject_pending)
        begin
          word[2*LANE_W] = ~word[2*LANE_W];
          inject_pending <= 1'b0;
          corrupt_cycle  <= cycle;
        end
        local_rdata       <= word;
        local_rdata_valid <= 1'b1;
        beats             <= beats + 1;
      end
      else
        local_rdata_valid <= 1'b0;

      // status goes idle, seq, dm, complete and never back
      if (test_status != prev_status)
        confirm((prev_status == 3'b000 && test_status == 3'b001) ||
                (prev_status == 3'b001 && test_status == 3'b010) ||
                (prev_status == 3'b010 && test_status == 3'b100),
                "test_status changed out of order");
      prev_status <= test_status;
      if (test_status.complete)
        confirm(!local_write_req && !local_read_req, "request raised after completion");

      if (clean_run)
      begin
        compare_value("pnf_per_byte", pnf_per_byte, {LANES{1'b1}});
        if (persist_seen)
          confirm(pnf_persist, "pnf_persist fell during the clean run");
        if (pnf_persist)
          persist_seen <= 1'b1;
      end
      else if (corrupt_cycle >= 0)
      begin
        // compare result 3 cycles after the beat and persist flag one later
        if (cycle == corrupt_cycle + 4)
          compare_value("pnf_per_byte", pnf_per_byte, 4'b1011);
        if (cycle >= corrupt_cycle + 5)
          compare_value("pnf_persist", pnf_persist, 1'b0);
      end
    end
  end

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic verify_reset_outputs();
    compare_value("local_write_req", local_write_req, 1'b0);
    compare_value("local_read_req", local_read_req, 1'b0);
    compare_value("pnf_persist", pnf_persist, 1'b0);
    compare_value("test_status", test_status, '0);
    compare_value("pnf_per_byte", pnf_per_byte, {LANES{1'b1}});
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset_n <= 1'b0;
    repeat (8)
    begin
      @(posedge clk);
      verify_reset_outputs();
    end
    reset_n <= 1'b1;
    @(posedge clk);
    verify_reset_outputs();
  endtask

  task automatic await_complete();
    while (!test_status.complete)
      @(posedge clk);
  endtask

  task automatic audit_masked_window();
    local_addr_t       a;
    logic [DATA_W-1:0] exp;
    for (int i = 0; i < WINDOW; i++)
    begin
      a = window_addr(i);
      confirm(mem.exists(a) && dm_be.exists(a), "window address never written");
      exp = '0;
      for (int l = 0; l < LANES; l++)
        if (dm_be[a][l])
          exp[l*LANE_W +: LANE_W] = dm_data[a][l*LANE_W +: LANE_W];
      compare_value("memory word", mem[a], exp);
    end
  endtask

  task automatic clean_traffic_test();
    clean_run <= 1'b1;
    apply_reset();
    await_complete();
    confirm(accepts == PASSES * WINDOW, "wrong number of accepted requests");
    confirm(beats == 2 * WINDOW, "wrong number of read beats returned");
    confirm(persist_seen, "pnf_persist never rose in the clean run");
    audit_masked_window();
    // idle after completion
    repeat (10)
      @(posedge clk);
  endtask

  task automatic lane_error_test();
    clean_run <= 1'b0;
    apply_reset();
    while (reads < WINDOW / 4)
      @(posedge clk);
    confirm(test_status.seq_mode, "injection point is outside the sequential read pass");
    confirm(pnf_persist, "pnf_persist was not high before the injected error");
    inject_pending <= 1'b1;
    await_complete();
    confirm(corrupt_cycle >= 0, "the corrupted read beat was never sent");
    compare_value("pnf_persist", pnf_persist, 1'b0);
  endtask

  initial
  begin : main
    reset_n           = 1'b0;
    local_ready       = 1'b0;
    local_rdata       = '0;
    local_rdata_valid = 1'b0;
    inject_pending    = 1'b0;
    clean_run         = 1'b1;
    clean_traffic_test();
    lane_error_test();
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, dut.u_sva.violations);
    if (mismatches + failures + dut.u_sva.violations == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin : watchdog
    wait (cycle >= TIMEOUT_CYCLES);
    $display("Error: no completion within %0d cycles", TIMEOUT_CYCLES);
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures + 1, dut.u_sva.violations);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== ddr_test_driver_sva.sv ====
/* local port protocol and reset checks bound into the traffic driver */
`timescale 1ns/1ns

module ddr_test_driver_sva
  import ddr_test_pkg::*;
(
  input logic              clk,
  input logic              reset_n,
  input logic              local_ready,
  input logic              local_write_req,
  input logic              local_read_req,
  input local_addr_t       local_addr,
  input logic [DATA_W-1:0] local_wdata,
  input logic [LANES-1:0]  local_be,
  input logic [LANES-1:0]  pnf_per_byte,
  input logic              pnf_persist,
  input test_status_t      test_status
);

  int violations = 0;

  // a stalled write keeps address, data and enables
  a_write_hold: assert property (@(posedge clk) disable iff (!reset_n)
    local_write_req && !local_ready |=>
      local_write_req && $stable(local_addr) && $stable(local_wdata) && $stable(local_be))
  else
  begin
    violations++;
    $error("write request changed while local_ready was low");
  end

  a_read_hold: assert property (@(posedge clk) disable iff (!reset_n)
    local_read_req && !local_ready |=> local_read_req && $stable(local_addr))
  else
  begin
    violations++;
    $error("read request changed while local_ready was low");
  end

  a_one_request: assert property (@(posedge clk) disable iff (!reset_n)
    !(local_write_req && local_read_req))
  else
  begin
    violations++;
    $error("read and write requests high together");
  end

  // outputs still idle on the first edge out of reset
  a_reset_idle: assert property (@(posedge clk)
    $rose(reset_n) |-> !local_write_req && !local_read_req && !pnf_persist &&
                       test_status == '0 && (&pnf_per_byte))
  else
  begin
    violations++;
    $error("outputs not at reset values when reset was released");
  end

endmodule

bind ddr_test_driver ddr_test_driver_sva u_sva (.*);

// ==== ddr_test_driver.sv ====
/* DDR SDRAM local port traffic driver
   sequential-address and data-mask tests with per-lane pass reporting */
`timescale 1ns/1ns

module ddr_test_driver
  import ddr_test_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic              local_ready,
  input  logic [DATA_W-1:0] local_rdata,
  input  logic              local_rdata_valid,
  output local_addr_t       local_addr,
  output logic              local_write_req,
  output logic              local_read_req,
  output logic [DATA_W-1:0] local_wdata,
  output logic [LANES-1:0]  local_be,
  output logic [LANES-1:0]  pnf_per_byte,
  output logic              pnf_persist,
  output test_status_t      test_status
);

  logic              advance;
  logic              addr_reset;
  logic              window_done;
  logic              write_accept;
  gen_ctrl_t         gen_ctrl;
  logic [DATA_W-1:0] expected;

  assign write_accept = advance & local_write_req;

  test_sequencer u_seq (
    .clk         (clk),
    .reset_n     (reset_n),
    .local_ready (local_ready),
    .rdata_valid (local_rdata_valid),
    .window_done (window_done),
    .write_req   (local_write_req),
    .read_req    (local_read_req),
    .advance     (advance),
    .addr_reset  (addr_reset),
    .gen_ctrl    (gen_ctrl),
    .status      (test_status)
  );

  test_addr_gen u_addr (
    .clk         (clk),
    .reset_n     (reset_n),
    .addr_reset  (addr_reset),
    .advance     (advance),
    .addr        (local_addr),
    .window_done (window_done)
  );

  test_data_gen u_data (
    .clk          (clk),
    .reset_n      (reset_n),
    .gen_ctrl     (gen_ctrl),
    .write_accept (write_accept),
    .rdata_valid  (local_rdata_valid),
    .wdata        (local_wdata),
    .expected     (expected)
  );

  byte_enable_gen u_be (
    .clk          (clk),
    .reset_n      (reset_n),
    .gen_ctrl     (gen_ctrl),
    .write_accept (write_accept),
    .rdata_valid  (local_rdata_valid),
    .be           (local_be)
  );

  read_checker u_check (
    .clk          (clk),
    .reset_n      (reset_n),
    .rdata        (local_rdata),
    .rdata_valid  (local_rdata_valid),
    .expected     (expected),
    .be           (local_be),
    .pnf_per_byte (pnf_per_byte),
    .pnf_persist  (pnf_persist)
  );

endmodule

// ==== test_sequencer.sv ====
/* test sequencer: sequential-address test then data-mask test,
   one request held until local_ready, read passes drained before moving on */
`timescale 1ns/1ns

module test_sequencer
  import ddr_test_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  logic         local_ready,
  input  logic         rdata_valid,
  input  logic         window_done,
  output logic         write_req,
  output logic         read_req,
  output logic         advance,
  output logic         addr_reset,
  output gen_ctrl_t    gen_ctrl,
  output test_status_t status
);

  typedef enum logic [2:0] {
    S_IDLE, S_CLR, S_WR_GO, S_WR, S_RD_GO, S_RD, S_RD_WAIT, S_DONE
  } state_t;

  state_t                   state;
  logic [OUTSTANDING_W-1:0] outstanding;
  logic                     read_accept;

  assign advance     = (write_req | read_req) & local_ready;
  assign read_accept = advance & read_req;

  // reads accepted but not yet returned
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      outstanding <= '0;
    else if (read_accept && !rdata_valid)
      outstanding <= outstanding + 1'b1;
    else if (!read_accept && rdata_valid && outstanding != '0)
      outstanding <= outstanding - 1'b1;
  end

  // ------------------------------
  // test FSM
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state      <= S_IDLE;
      write_req  <= 1'b0;
      read_req   <= 1'b0;
      addr_reset <= 1'b0;
      gen_ctrl   <= '0;
      status     <= '0;
    end
    else
    begin
      // single-cycle strobes
      addr_reset            <= 1'b0;
      gen_ctrl.load         <= 1'b0;
      gen_ctrl.capture_seed <= 1'b0;
      case (state)
        S_IDLE:
        begin
          status.seq_mode <= 1'b1;
          state           <= S_WR_GO;
        end
        // zero the window with every lane enabled
        S_CLR:
          if (advance && window_done)
          begin
            write_req          <= 1'b0;
            gen_ctrl.zero_data <= 1'b0;
            addr_reset         <= 1'b1;
            state              <= S_WR_GO;
          end
        S_WR_GO:
        begin
          write_req             <= 1'b1;
          gen_ctrl.capture_seed <= 1'b1;
          state                 <= S_WR;
        end
        S_WR:
          if (advance && window_done)
          begin
            write_req     <= 1'b0;
            addr_reset    <= 1'b1;
            gen_ctrl.load <= 1'b1;
            state         <= S_RD_GO;
          end
        S_RD_GO:
        begin
          read_req <= 1'b1;
          state    <= S_RD;
        end
        S_RD:
          if (advance && window_done)
          begin
            read_req   <= 1'b0;
            addr_reset <= 1'b1;
            state      <= S_RD_WAIT;
          end
        S_RD_WAIT:
          if (outstanding == '0)
          begin
            if (!status.dm_mode)
            begin
              status.seq_mode    <= 1'b0;
              status.dm_mode     <= 1'b1;
              gen_ctrl.dm_mode   <= 1'b1;
              gen_ctrl.zero_data <= 1'b1;
              write_req          <= 1'b1;
              state              <= S_CLR;
            end
            else
            begin
              status.dm_mode   <= 1'b0;
              gen_ctrl.dm_mode <= 1'b0;
              status.complete  <= 1'b1;
              state            <= S_DONE;
            end
          end
        S_DONE:
          state <= S_DONE;
        default:
          state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== read_checker.sv ====
/* read data checker: per-lane masked compare through three register stages,
   with a persistent pass flag that latches low on the first failing beat */
`timescale 1ns/1ns

module read_checker
  import ddr_test_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic [DATA_W-1:0] rdata,
  input  logic              rdata_valid,
  input  logic [DATA_W-1:0] expected,
  input  logic [LANES-1:0]  be,
  output logic [LANES-1:0]  pnf_per_byte,
  output logic              pnf_persist
);

  logic [LANES-1:0] lane_match;
  logic [LANES-1:0] match_q;
  logic [LANES-1:0] match_valid;
  logic [LANES-1:0] match_out;
  logic             valid_q;
  logic [2:0]       seen;
  logic             persist_int;

  // masked lanes must read back as zero
  always_comb
  begin
    for (int i = 0; i < LANES; i++)
      lane_match[i] = (expected[i*LANE_W +: LANE_W] & {LANE_W{be[i]}})
                      == rdata[i*LANE_W +: LANE_W];
  end

  // ------------------------------
  // compare pipeline
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      match_q     <= '1;
      match_valid <= '1;
      match_out   <= '1;
      valid_q     <= 1'b0;
      seen        <= '0;
      persist_int <= 1'b0;
      pnf_persist <= 1'b0;
    end
    else
    begin
      match_q <= lane_match;
      valid_q <= rdata_valid;
      // keep the last real beat between valid cycles
      if (valid_q)
        match_valid <= match_q;
      match_out <= match_valid;
      // read data seen, delayed to line up with the compare stages
      seen <= {seen[1:0], seen[0] | rdata_valid};
      persist_int <= (&match_valid) & seen[1] & (seen[2] ? persist_int : 1'b1);
      pnf_persist <= persist_int;
    end
  end

  assign pnf_per_byte = match_out;

endmodule

// ==== byte_enable_gen.sv ====
/* byte enable generator, a single lane rotating left during data-mask passes */
`timescale 1ns/1ns

module byte_enable_gen
  import ddr_test_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  input  gen_ctrl_t        gen_ctrl,
  input  logic             write_accept,
  input  logic             rdata_valid,
  output logic [LANES-1:0] be
);

  logic             active;
  logic [LANES-1:0] rot;

  // the clear pass writes every lane
  assign active = gen_ctrl.dm_mode & ~gen_ctrl.zero_data;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      rot <= LANES'(1);
    else if (gen_ctrl.load)
      rot <= LANES'(1);
    else if (active && (write_accept || rdata_valid))
      rot <= {rot[LANES-2:0], rot[LANES-1]};
  end

  assign be = active ? rot : '1;

endmodule

// ==== test_addr_gen.sv ====
/* sequential address counter over the test window
   column first, then row, bank and chip select, wrapping after the last address */
`timescale 1ns/1ns

module test_addr_gen
  import ddr_test_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        addr_reset,
  input  logic        advance,
  output local_addr_t addr,
  output logic        window_done
);

  logic col_last;
  logic row_last;
  logic bank_last;
  logic cs_last;

  assign col_last  = addr.col  == COL_W'(MAX_COL);
  assign row_last  = addr.row  == ROW_W'(MAX_ROW);
  assign bank_last = addr.bank == BANK_W'(MAX_BANK);
  assign cs_last   = addr.cs   == CS_W'(MAX_CS);

  assign window_done = col_last & row_last & bank_last & cs_last;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      addr <= '0;
    else if (addr_reset)
      addr <= '0;
    else if (advance)
    begin
      if (!col_last)
        addr.col <= addr.col + COL_W'(COL_STEP);
      else
      begin
        addr.col <= '0;
        // carry chain into the upper fields
        if (!row_last)
          addr.row <= addr.row + 1'b1;
        else
        begin
          addr.row <= '0;
          if (!bank_last)
            addr.bank <= addr.bank + 1'b1;
          else
          begin
            addr.bank <= '0;
            addr.cs   <= cs_last ? '0 : addr.cs + 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== test_data_gen.sv ====
/* test data generator: four seeded LFSR lanes with reload storage
   so a read pass replays the sequence of the write pass before it */
`timescale 1ns/1ns

module test_data_gen
  import ddr_test_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  gen_ctrl_t         gen_ctrl,
  input  logic              write_accept,
  input  logic              rdata_valid,
  output logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] expected
);

  logic              step;
  logic [DATA_W-1:0] lfsr_state;
  logic [DATA_W-1:0] seed_store;

  // zero writes of the clear pass do not consume data
  assign step = (write_accept & ~gen_ctrl.zero_data) | rdata_valid;

  // state at the start of a write pass, restored before the read pass
  always_ff @(posedge clk)
  begin
    if (gen_ctrl.capture_seed)
      seed_store <= lfsr_state;
  end

  for (genvar i = 0; i < LANES; i++)
  begin : g_lane
    lfsr8 #(.seed(LFSR_SEEDS[i])) u_lfsr (
      .clk     (clk),
      .reset_n (reset_n),
      .load    (gen_ctrl.load),
      .ldata   (seed_store[i*LANE_W +: LANE_W]),
      .step    (step),
      .data    (lfsr_state[i*LANE_W +: LANE_W])
    );
  end

  assign wdata    = gen_ctrl.zero_data ? '0 : lfsr_state;
  assign expected = lfsr_state;

endmodule

// ==== lfsr8.sv ====
/* 8-bit Galois LFSR with parallel load and step enable */
`timescale 1ns/1ns

module lfsr8
  import ddr_test_pkg::*;
#(
  parameter logic [7:0] seed = 8'd1
)
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       load,
  input  logic [7:0] ldata,
  input  logic       step,
  output logic [7:0] data
);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      data <= seed;
    else if (load)
      data <= ldata;
    else if (step)
      // shift right, fold taps in when the low bit falls out
      data <= (data >> 1) ^ ({8{data[0]}} & LFSR_TAPS);
  end

endmodule

// ==== ddr_test_pkg.sv ====
/* DDR test driver shared definitions
   local port widths, test window limits, LFSR seeds and common struct types */
package ddr_test_pkg;

  // ------------------------------
  // local port data path
  // ------------------------------
  localparam int DATA_W = 32;
  localparam int LANES  = 4;
  localparam int LANE_W = 8;

  // address field widths
  localparam int CS_W   = 1;
  localparam int BANK_W = 2;
  localparam int ROW_W  = 13;
  localparam int COL_W  = 11;

  // last address of the test window, column counts in COL_STEP units
  localparam int MAX_CS   = 1;
  localparam int MAX_BANK = 3;
  localparam int MAX_ROW  = 3;
  localparam int MAX_COL  = 16;
  localparam int COL_STEP = 4;

  // ------------------------------
  // data generation
  // ------------------------------
  // lane 0 in the low byte
  localparam logic [LANES-1:0][LANE_W-1:0] LFSR_SEEDS = {8'd31, 8'd21, 8'd11, 8'd1};
  localparam logic [LANE_W-1:0] LFSR_TAPS = 8'hB8;

  localparam int OUTSTANDING_W = 8;

  typedef struct packed {
    logic [CS_W-1:0]   cs;
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
    logic [COL_W-1:0]  col;
  } local_addr_t;

  typedef struct packed {
    logic complete;
    logic dm_mode;
    logic seq_mode;
  } test_status_t;

  // sequencer commands to the data and byte enable generators
  typedef struct packed {
    logic load;
    logic capture_seed;
    logic zero_data;
    logic dm_mode;
  } gen_ctrl_t;

endpackage
